// File: build.f
+incdir+design
design/dbg_types_pkg.sv
design/wb_types_pkg.sv
design/dbg_req_if.sv
design/dbg_req_latch.sv
design/wb_xfer_fsm.sv
design/wb_ack_timer.sv
design/wb_rdata_path.sv
design/dbg_wb_bridge.sv
tests/dbg_wb_checker.sv
tests/tb_dbg_wb_bridge.sv

// File: design/dbg_req_if.sv
/* Latched debug request, carried from the TCK domain to the Wishbone domain */

`default_nettype none

interface dbg_req_if import dbg_types_pkg::*, wb_types_pkg::*; ();

  // Request payload, held stable while rdy_o is low
  dbg_addr_t adr;
  dbg_data_t wdat;
  wb_sel_t   sel;
  logic      we;

  // Flips once per accepted strobe
  // Only this one crosses through synchronizers
  logic      str_tgl;

  // TCK side, owns every signal
  modport src (output adr, output wdat, output sel, output we, output str_tgl);

  // Wishbone side, reads payload directly
  modport dst (input adr, input wdat, input sel, input we, input str_tgl);

endinterface

`default_nettype wire

// File: design/dbg_req_latch.sv
/* TCK-domain half of the bridge: lane decode, write-data steering,
   request latch, start toggle and the rdy_o handshake */

`default_nettype none

`include "dbg_wb_cfg.svh"

module dbg_req_latch import dbg_types_pkg::*, wb_types_pkg::*; (
  input  wire        tck_i,
  input  wire        rst_i,
  input  wire        strobe_i,
  input  wire        rd_wrn_i,
  input  dbg_addr_t  addr_i,
  input  dbg_data_t  data_i,
  input  dbg_wsize_t word_size_i,
  input  wire        rdy_tgl_i,
  output logic       rdy_o,
  dbg_req_if.src     req
);

  localparam bit LittleEndian = `DBG_WB_LITTLE_ENDIAN;

  wb_sel_t   le_sel;
  wb_sel_t   lane_sel;
  dbg_data_t lane_wdat;
  logic      accept;
  logic      rdy_ff1;
  logic      rdy_ff2;
  logic      rdy_ff2q;

  //////////////////////////////
  // Lane decode
  //////////////////////////////

  // Little-endian select from size and low address bits
  always_comb begin
    case (word_size_i)
      WSIZE_BYTE: le_sel = wb_sel_t'(4'b0001 << addr_i[1:0]);
      WSIZE_HALF: le_sel = addr_i[1] ? 4'b1100 : 4'b0011;
      default:    le_sel = 4'b1111;
    endcase
  end

  // Big-endian order is the mirror image
  assign lane_sel = LittleEndian ? le_sel : {le_sel[0], le_sel[1], le_sel[2], le_sel[3]};

  // Short values arrive in the top bits of data_i
  // Move them down onto the selected lanes
  always_comb begin
    case (lane_sel)
      4'b0001: lane_wdat = {24'h0, data_i[31:24]};
      4'b0010: lane_wdat = {16'h0, data_i[31:24], 8'h0};
      4'b0100: lane_wdat = {8'h0, data_i[31:24], 16'h0};
      4'b1000: lane_wdat = {data_i[31:24], 24'h0};
      4'b0011: lane_wdat = {16'h0, data_i[31:16]};
      default: lane_wdat = data_i;  // Upper halfword or full word already in place
    endcase
  end

  //////////////////////////////
  // Request latch
  //////////////////////////////

  // Strobe counts only while idle
  assign accept = strobe_i && rdy_o;

  always_ff @(posedge tck_i) begin
    if (accept) begin
      req.adr <= addr_i;
      req.sel <= lane_sel;
      req.we  <= ~rd_wrn_i;
      // Write data only matters for writes
      if (!rd_wrn_i) begin
        req.wdat <= lane_wdat;
      end
    end
  end

  // Start toggle toward the Wishbone domain
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      req.str_tgl <= 1'b0;
    end else if (accept) begin
      req.str_tgl <= ~req.str_tgl;
    end
  end

  //////////////////////////////
  // Ready return
  //////////////////////////////

  // Two-stage sync of the ready toggle, third stage for edge detect
  // rdy_o drops on accept, rises on a toggle
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rdy_ff1  <= 1'b0;
      rdy_ff2  <= 1'b0;
      rdy_ff2q <= 1'b0;
      rdy_o    <= 1'b1;
    end else begin
      rdy_ff1  <= rdy_tgl_i;
      rdy_ff2  <= rdy_ff1;
      rdy_ff2q <= rdy_ff2;
      if (accept) begin
        rdy_o <= 1'b0;
      end else if (rdy_ff2 != rdy_ff2q) begin
        rdy_o <= 1'b1;
      end
    end
  end

  // A new request only goes out from the idle state
  a_accept_when_ready: assert property (
    @(posedge tck_i) disable iff (rst_i)
    $changed(req.str_tgl) |-> $past(rdy_o) && !rdy_o
  );

endmodule

`default_nettype wire

// File: design/dbg_types_pkg.sv
/* Debug-side types: byte address, data word, word-size code */

`default_nettype none

package dbg_types_pkg;

  // Byte address from the debug unit
  typedef logic [31:0] dbg_addr_t;

  // Data word in both directions
  typedef logic [31:0] dbg_data_t;

  // Word-size code, any other value counts as a full word
  typedef logic [2:0] dbg_wsize_t;

  // Size codes with their own lane decode
  localparam dbg_wsize_t WSIZE_BYTE = 3'd1;
  localparam dbg_wsize_t WSIZE_HALF = 3'd2;

endpackage

`default_nettype wire

// File: design/dbg_wb_bridge.sv
/* Debug port to Wishbone bridge top level
   TCK request latch, Wishbone FSM, ack watchdog and read-data path */

`default_nettype none

module dbg_wb_bridge import dbg_types_pkg::*, wb_types_pkg::*; (
  // Debug side
  input  wire        tck_i,
  input  wire        wb_clk_i,
  input  wire        rst_i,
  input  dbg_data_t  data_i,       // Short values in the upper bits
  output dbg_data_t  data_o,       // Right-aligned read result
  input  dbg_addr_t  addr_i,
  input  wire        strobe_i,
  input  wire        rd_wrn_i,
  output logic       rdy_o,
  output logic       err_o,
  input  dbg_wsize_t word_size_i,

  // Wishbone master
  output dbg_addr_t  wb_adr_o,
  output dbg_data_t  wb_dat_o,
  input  dbg_data_t  wb_dat_i,
  output logic       wb_cyc_o,
  output logic       wb_stb_o,
  output wb_sel_t    wb_sel_o,
  output logic       wb_we_o,
  input  wire        wb_ack_i,
  input  wire        wb_err_i
);

  // Cross-domain and block-to-block signals
  logic rdy_tgl;
  logic timer_run;
  logic timer_expired;
  logic res_load;
  logic res_err;

  // Request bundle, TCK side writes it, Wishbone side reads it
  dbg_req_if req ();

  //////////////////////////////
  // TCK domain
  //////////////////////////////

  dbg_req_latch u_latch (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .strobe_i    (strobe_i),
    .rd_wrn_i    (rd_wrn_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .word_size_i (word_size_i),
    .rdy_tgl_i   (rdy_tgl),
    .rdy_o       (rdy_o),
    .req         (req.src)
  );

  //////////////////////////////
  // Wishbone domain
  //////////////////////////////

  wb_xfer_fsm u_fsm (
    .wb_clk_i        (wb_clk_i),
    .rst_i           (rst_i),
    .req             (req.dst),
    .wb_ack_i        (wb_ack_i),
    .wb_err_i        (wb_err_i),
    .timer_expired_i (timer_expired),
    .wb_cyc_o        (wb_cyc_o),
    .wb_stb_o        (wb_stb_o),
    .timer_run_o     (timer_run),
    .res_load_o      (res_load),
    .res_err_o       (res_err),
    .rdy_tgl_o       (rdy_tgl)
  );

  wb_ack_timer u_timer (
    .wb_clk_i        (wb_clk_i),
    .rst_i           (rst_i),
    .timer_run_i     (timer_run),
    .timer_expired_o (timer_expired)
  );

  wb_rdata_path u_rdata (
    .wb_clk_i   (wb_clk_i),
    .rst_i      (rst_i),
    .req        (req.dst),
    .wb_dat_i   (wb_dat_i),
    .res_load_i (res_load),
    .res_err_i  (res_err),
    .data_o     (data_o),
    .err_o      (err_o)
  );

  // Payload is stable while the cycle is open
  assign wb_adr_o = req.adr;
  assign wb_dat_o = req.wdat;
  assign wb_sel_o = req.sel;
  assign wb_we_o  = req.we;

endmodule

`default_nettype wire

// File: design/dbg_wb_cfg.svh
/* Build-time configuration of the debug to Wishbone bridge
   Watchdog limit and byte-lane order */

`ifndef DBG_WB_CFG_SVH
`define DBG_WB_CFG_SVH

// Wishbone clocks an open cycle may wait for ack or err
// Expiry closes the cycle with an error
`define DBG_WB_ACK_TIMEOUT 16

// Byte-lane order on the 32-bit bus
// 1: lowest address on the least significant lane
// 0: lowest address on the most significant lane
`define DBG_WB_LITTLE_ENDIAN 1'b1

`endif

// File: design/wb_ack_timer.sv
/* Acknowledge watchdog: counts wait clocks of an open cycle */

`default_nettype none

`include "dbg_wb_cfg.svh"

module wb_ack_timer import wb_types_pkg::*; (
  input  wire  wb_clk_i,
  input  wire  rst_i,
  input  wire  timer_run_i,
  output logic timer_expired_o
);

  localparam wb_tcnt_t Limit = wb_tcnt_t'(`DBG_WB_ACK_TIMEOUT);

  wb_tcnt_t cnt_q;

  // Cleared while no cycle is open
  // Counts up and holds at the limit
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (!timer_run_i) begin
      cnt_q <= '0;
    end else if (cnt_q != Limit) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Count equals clocks already waited
  // Masked by run so a held count never leaks into the next cycle
  assign timer_expired_o = timer_run_i && (cnt_q == Limit);

endmodule

`default_nettype wire

// File: design/wb_rdata_path.sv
/* Read-data lane extraction and the data and error result registers */

`default_nettype none

module wb_rdata_path import dbg_types_pkg::*; (
  input  wire       wb_clk_i,
  input  wire       rst_i,
  dbg_req_if.dst    req,
  input  dbg_data_t wb_dat_i,
  input  wire       res_load_i,
  input  wire       res_err_i,
  output dbg_data_t data_o,
  output logic      err_o
);

  dbg_data_t lane_rdat;

  // Selected lanes moved down to bit 0, upper bits zero
  always_comb begin
    case (req.sel)
      4'b0001: lane_rdat = {24'h0, wb_dat_i[7:0]};
      4'b0010: lane_rdat = {24'h0, wb_dat_i[15:8]};
      4'b0100: lane_rdat = {24'h0, wb_dat_i[23:16]};
      4'b1000: lane_rdat = {24'h0, wb_dat_i[31:24]};
      4'b0011: lane_rdat = {16'h0, wb_dat_i[15:0]};
      4'b1100: lane_rdat = {16'h0, wb_dat_i[31:16]};
      default: lane_rdat = wb_dat_i;
    endcase
  end

  //////////////////////////////
  // Result registers
  //////////////////////////////

  // Error flag follows every closed cycle
  // Data only from reads that ended with ack
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      data_o <= '0;
      err_o  <= 1'b0;
    end else if (res_load_i) begin
      err_o <= res_err_i;
      if (!req.we && !res_err_i) begin
        data_o <= lane_rdat;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/wb_types_pkg.sv
/* Wishbone-side types: byte select, watchdog count, transfer state */

`default_nettype none

`include "dbg_wb_cfg.svh"

package wb_types_pkg;

  // One bit per byte lane
  typedef logic [3:0] wb_sel_t;

  // Watchdog count, must reach the limit itself
  typedef logic [$clog2(`DBG_WB_ACK_TIMEOUT + 1)-1:0] wb_tcnt_t;

  // Transfer FSM
  typedef enum logic [0:0] {
    XFER_IDLE,  // No cycle open
    XFER_WAIT   // Cycle open, waiting for a reply
  } wb_xfer_state_e;

endpackage

`default_nettype wire

// File: design/wb_xfer_fsm.sv
/* Wishbone-domain transfer control: start synchronizer,
   single-cycle FSM and the ready toggle back to TCK */

`default_nettype none

module wb_xfer_fsm import wb_types_pkg::*; (
  input  wire    wb_clk_i,
  input  wire    rst_i,
  dbg_req_if.dst req,
  input  wire    wb_ack_i,
  input  wire    wb_err_i,
  input  wire    timer_expired_i,
  output logic   wb_cyc_o,
  output logic   wb_stb_o,
  output logic   timer_run_o,
  output logic   res_load_o,
  output logic   res_err_o,
  output logic   rdy_tgl_o
);

  wb_xfer_state_e state_q;
  wb_xfer_state_e state_d;
  logic           str_ff1;
  logic           str_ff2;
  logic           str_ff2q;
  logic           start;
  logic           reply;
  logic           close;

  //////////////////////////////
  // Start synchronizer
  //////////////////////////////

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      str_ff1  <= 1'b0;
      str_ff2  <= 1'b0;
      str_ff2q <= 1'b0;
    end else begin
      str_ff1  <= req.str_tgl;
      str_ff2  <= str_ff1;
      str_ff2q <= str_ff2;
    end
  end

  // One-clock pulse per new request
  assign start = str_ff2 ^ str_ff2q;

  // Watchdog expiry ends the cycle just like a slave reply
  assign reply = wb_ack_i | wb_err_i | timer_expired_i;

  //////////////////////////////
  // Transfer FSM
  //////////////////////////////

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= XFER_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Cycle opens combinationally on the detect cycle
  // A reply in that same cycle skips XFER_WAIT
  always_comb begin
    state_d  = state_q;
    wb_cyc_o = 1'b0;
    wb_stb_o = 1'b0;
    case (state_q)
      XFER_IDLE: begin
        if (start) begin
          wb_cyc_o = 1'b1;
          wb_stb_o = 1'b1;
          if (!reply) begin
            state_d = XFER_WAIT;
          end
        end
      end
      XFER_WAIT: begin
        wb_cyc_o = 1'b1;
        wb_stb_o = 1'b1;
        if (reply) begin
          state_d = XFER_IDLE;
        end
      end
      default: state_d = XFER_IDLE;
    endcase
  end

  // Closing edge of the open cycle
  assign close       = wb_cyc_o & reply;
  assign timer_run_o = wb_cyc_o;
  assign res_load_o  = close;
  assign res_err_o   = wb_err_i | timer_expired_i;

  // Ready toggle flips on the closing edge
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      rdy_tgl_o <= 1'b0;
    end else if (close) begin
      rdy_tgl_o <= ~rdy_tgl_o;
    end
  end

  // Slave must not answer with both ack and err
  a_ack_err_excl: assert property (
    @(posedge wb_clk_i) disable iff (rst_i)
    wb_stb_o |-> !(wb_ack_i && wb_err_i)
  );

  a_stb_in_cyc: assert property (
    @(posedge wb_clk_i) disable iff (rst_i)
    wb_stb_o |-> wb_cyc_o
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module tb_dbg_wb_bridge -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

// File: tests/dbg_wb_checker.sv
/* Bus checker: predicts each Wishbone cycle from the debug request
   and compares bus and result values with the expected ones */

`default_nettype none

`include "dbg_wb_cfg.svh"

module dbg_wb_checker (
  input  wire        tck_i,
  input  wire        wb_clk_i,
  input  wire        rst_i,
  input  wire        strobe_i,
  input  wire        rd_wrn_i,
  input  wire [31:0] addr_i,
  input  wire [31:0] data_i,
  input  wire [2:0]  word_size_i,
  input  wire        dbg_rdy_i,
  input  wire [31:0] dbg_rdata_i,
  input  wire        dbg_err_i,
  input  wire [31:0] wb_adr_i,
  input  wire [31:0] wb_wdat_i,
  input  wire        wb_cyc_i,
  input  wire        wb_stb_i,
  input  wire [3:0]  wb_sel_i,
  input  wire        wb_we_i,
  input  wire [31:0] exp_data_i,
  input  wire        exp_err_i,
  output int         errors_o
);

  localparam int MaxCyc = `DBG_WB_ACK_TIMEOUT + 1;

  int          errors_tck = 0;
  int          errors_wb = 0;
  int          n_accept = 0;
  int          n_open = 0;
  int          cyc_len = 0;
  logic        rdy_q = 1'b1;
  logic        cyc_q = 1'b0;
  logic        rst_q = 1'b0;
  logic [31:0] exp_adr = '0;
  logic        exp_we = 1'b0;
  logic [3:0]  exp_sel = '0;
  logic [31:0] exp_wdat = '0;
  logic [31:0] exp_mask = '0;

  assign errors_o = errors_tck + errors_wb;

  // Bytes moved by a size code, unknown codes mean a full word
  function automatic int size_bytes(input logic [2:0] size);
    return (size == 3'd1) ? 1 : (size == 3'd2) ? 2 : 4;
  endfunction

  task automatic show_error(input string msg);
    $display("error %0t: %s", $time, msg);
  endtask

  //////////////////////////////
  // Debug side
  //////////////////////////////

  always @(posedge tck_i) begin : watch_debug
    int n;
    int ofs;
    n = size_bytes(word_size_i);
    // Offset rounded down to the access size
    ofs = int'(addr_i[1:0]) & ~(n - 1);
    if (!rst_i && strobe_i && dbg_rdy_i) begin
      n_accept++;
      exp_adr  = addr_i;
      exp_we   = !rd_wrn_i;
      exp_sel  = 4'(((1 << n) - 1) << ofs);
      // Short value sits in the top bits, goes to its lanes
      exp_wdat = (data_i >> (32 - 8 * n)) << (8 * ofs);
      for (int b = 0; b < 4; b++) begin
        exp_mask[8*b +: 8] = {8{exp_sel[b]}};
      end
    end
    // Rise of rdy_o ends a transfer
    if (!rst_i && dbg_rdy_i && !rdy_q) begin
      if (n_open != n_accept) begin
        $display("The Wishbone cycle for address %h never opened", exp_adr);
        errors_tck++;
      end
      if (dbg_err_i !== exp_err_i) begin
        show_error($sformatf("err_o is %b, expected %b", dbg_err_i, exp_err_i));
        errors_tck++;
      end
      if (dbg_rdata_i !== exp_data_i) begin
        show_error($sformatf("data_o is %h, expected %h", dbg_rdata_i, exp_data_i));
        errors_tck++;
      end
    end
    rdy_q = dbg_rdy_i;
  end

  //////////////////////////////
  // Wishbone side
  //////////////////////////////

  always @(posedge wb_clk_i) begin : watch_bus
    if (rst_q && !rst_i) begin
      if (!dbg_rdy_i || wb_cyc_i || dbg_err_i || dbg_rdata_i !== '0) begin
        show_error("state after reset is wrong");
        errors_wb++;
      end
    end
    if (!rst_i && wb_cyc_i) begin
      if (!cyc_q) begin
        if (n_open >= n_accept) begin
          $display("A Wishbone cycle opened without an accepted strobe");
          errors_wb++;
        end
        n_open++;
        cyc_len = 0;
      end
      cyc_len++;
      if (cyc_len == MaxCyc + 1) begin
        show_error("cycle stays open past the watchdog limit");
        errors_wb++;
      end
      if (!wb_stb_i || wb_adr_i !== exp_adr || wb_we_i !== exp_we || wb_sel_i !== exp_sel) begin
        show_error($sformatf("bus adr %h we %b sel %b, expected %h %b %b",
                             wb_adr_i, wb_we_i, wb_sel_i, exp_adr, exp_we, exp_sel));
        errors_wb++;
      end
      // Only the selected lanes carry write data
      if (exp_we && ((wb_wdat_i ^ exp_wdat) & exp_mask) != '0) begin
        show_error($sformatf("wb_dat_o is %h, expected %h on lanes %b",
                             wb_wdat_i, exp_wdat, exp_sel));
        errors_wb++;
      end
    end
    cyc_q = wb_cyc_i;
    rst_q = rst_i;
  end

endmodule

`default_nettype wire

// File: tests/tb_dbg_wb_bridge.sv
/* Testbench of the debug to Wishbone bridge: clocks, reset, stimulus
   table, Wishbone slave model with memory and the final report */

`default_nettype none

module tb_dbg_wb_bridge;

  localparam int NumRows = 24;
  localparam int RdyTimeout = 200;

  // One debug transfer with its expected result
  typedef struct packed {
    logic [31:0] adr;
    logic        rd;
    logic [2:0]  size;
    logic [31:0] wdat;
    logic [31:0] rdat;
    logic        err;
  } row_t;

  logic        tck_i = 1'b0;
  logic        wb_clk_i = 1'b0;
  logic        rst_i = 1'b1;
  logic [31:0] data_i = '0;
  logic [31:0] addr_i = '0;
  logic        strobe_i = 1'b0;
  logic        rd_wrn_i = 1'b1;
  logic [2:0]  word_size_i = 3'd4;
  logic [31:0] wb_dat_i = '0;
  logic        wb_ack_i = 1'b0;
  logic        wb_err_i = 1'b0;
  wire  [31:0] data_o;
  wire         rdy_o;
  wire         err_o;
  wire  [31:0] wb_adr_o;
  wire  [31:0] wb_dat_o;
  wire         wb_cyc_o;
  wire         wb_stb_o;
  wire  [3:0]  wb_sel_o;
  wire         wb_we_o;

  integer      seed = 32'hd7be_3e08;
  row_t        rows [NumRows];
  logic [31:0] mem [16];
  logic [31:0] exp_data = '0;
  logic        exp_err = 1'b0;
  int          chk_errors;
  int          timeouts = 0;
  logic        busy = 1'b0;
  int          wait_left = 0;

  dbg_wb_bridge dut0 (
    .tck_i       (tck_i),
    .wb_clk_i    (wb_clk_i),
    .rst_i       (rst_i),
    .data_i      (data_i),
    .data_o      (data_o),
    .addr_i      (addr_i),
    .strobe_i    (strobe_i),
    .rd_wrn_i    (rd_wrn_i),
    .rdy_o       (rdy_o),
    .err_o       (err_o),
    .word_size_i (word_size_i),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_o    (wb_dat_o),
    .wb_dat_i    (wb_dat_i),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_sel_o    (wb_sel_o),
    .wb_we_o     (wb_we_o),
    .wb_ack_i    (wb_ack_i),
    .wb_err_i    (wb_err_i)
  );

  dbg_wb_checker chk0 (
    .tck_i       (tck_i),
    .wb_clk_i    (wb_clk_i),
    .rst_i       (rst_i),
    .strobe_i    (strobe_i),
    .rd_wrn_i    (rd_wrn_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .word_size_i (word_size_i),
    .dbg_rdy_i   (rdy_o),
    .dbg_rdata_i (data_o),
    .dbg_err_i   (err_o),
    .wb_adr_i    (wb_adr_o),
    .wb_wdat_i   (wb_dat_o),
    .wb_cyc_i    (wb_cyc_o),
    .wb_stb_i    (wb_stb_o),
    .wb_sel_i    (wb_sel_o),
    .wb_we_i     (wb_we_o),
    .exp_data_i  (exp_data),
    .exp_err_i   (exp_err),
    .errors_o    (chk_errors)
  );

  //////////////////////////////
  // Clocks
  //////////////////////////////

  initial begin
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  // TCK unrelated to the bus clock
  initial begin
    forever #7 tck_i = ~tck_i;
  end

  //////////////////////////////
  // Wishbone slave model
  //////////////////////////////

  // 0x100-0x1FF answer err, 0x200-0x2FF never answer
  always @(posedge wb_clk_i) begin : slave_model
    logic [3:0] idx;
    idx = wb_adr_o[5:2];
    wb_ack_i <= 1'b0;
    wb_err_i <= 1'b0;
    if (rst_i) begin
      for (int i = 0; i < 16; i++) begin
        mem[i] = 32'h6b00_0000 ^ (i * 32'h0013_2b07);
      end
      busy = 1'b0;
    end else if (!wb_cyc_o) begin
      busy = 1'b0;
    end else if (wb_stb_o && !wb_ack_i && !wb_err_i) begin
      // Random wait of 0 to 3 clocks, drawn once per cycle
      if (!busy) begin
        busy = 1'b1;
        wait_left = $random(seed) & 3;
      end
      if (wait_left > 0) begin
        wait_left = wait_left - 1;
      end else if (wb_adr_o[31:8] == 24'h1) begin
        wb_err_i <= 1'b1;
      end else if (wb_adr_o[31:8] != 24'h2) begin
        wb_ack_i <= 1'b1;
        for (int b = 0; b < 4; b++) begin
          if (wb_we_o && wb_sel_o[b]) begin
            mem[idx][8*b +: 8] = wb_dat_o[8*b +: 8];
          end
        end
        wb_dat_i <= mem[idx];
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // One debug transfer, strobe held into the first busy cycle
  task automatic run_row(input row_t row);
    int n;
    n = 0;
    while (!rdy_o && n < RdyTimeout) begin
      @(posedge tck_i);
      n++;
    end
    @(posedge tck_i);
    addr_i      <= row.adr;
    rd_wrn_i    <= row.rd;
    word_size_i <= row.size;
    data_i      <= row.wdat;
    exp_data    <= row.rdat;
    exp_err     <= row.err;
    strobe_i    <= 1'b1;
    @(posedge tck_i);
    // Second edge sees rdy_o low, strobe must be ignored
    // A changed address there would reach the bus if it were taken
    addr_i <= row.adr ^ 32'h0000_0040;
    @(posedge tck_i);
    strobe_i <= 1'b0;
    n = 0;
    while (!rdy_o && n < RdyTimeout) begin
      @(posedge tck_i);
      n++;
    end
    if (!rdy_o) begin
      $display("rdy_o did not rise within %0d tck cycles for address %h", RdyTimeout, row.adr);
      timeouts++;
    end
  endtask

  initial begin : stimulus
    // Address, read, size, write data, expected data_o, expected err_o
    rows[0]  = '{32'h000, 1'b0, 3'd4, 32'h1234_5678, 32'h0, 1'b0};
    rows[1]  = '{32'h000, 1'b1, 3'd4, 32'h0, 32'h1234_5678, 1'b0};
    rows[2]  = '{32'h004, 1'b0, 3'd4, 32'h0, 32'h1234_5678, 1'b0};
    rows[3]  = '{32'h005, 1'b0, 3'd1, 32'hab00_0000, 32'h1234_5678, 1'b0};
    rows[4]  = '{32'h007, 1'b0, 3'd1, 32'hcd00_0000, 32'h1234_5678, 1'b0};
    rows[5]  = '{32'h004, 1'b1, 3'd4, 32'h0, 32'hcd00_ab00, 1'b0};
    rows[6]  = '{32'h008, 1'b0, 3'd4, 32'hdead_beef, 32'hcd00_ab00, 1'b0};
    rows[7]  = '{32'h00a, 1'b0, 3'd2, 32'h5566_0000, 32'hcd00_ab00, 1'b0};
    rows[8]  = '{32'h005, 1'b1, 3'd1, 32'h0, 32'h0000_00ab, 1'b0};
    rows[9]  = '{32'h007, 1'b1, 3'd1, 32'h0, 32'h0000_00cd, 1'b0};
    rows[10] = '{32'h00a, 1'b1, 3'd2, 32'h0, 32'h0000_5566, 1'b0};
    rows[11] = '{32'h008, 1'b1, 3'd2, 32'h0, 32'h0000_beef, 1'b0};
    rows[12] = '{32'h009, 1'b1, 3'd1, 32'h0, 32'h0000_00be, 1'b0};
    rows[13] = '{32'h008, 1'b1, 3'd4, 32'h0, 32'h5566_beef, 1'b0};
    rows[14] = '{32'h104, 1'b1, 3'd4, 32'h0, 32'h5566_beef, 1'b1};
    rows[15] = '{32'h000, 1'b1, 3'd4, 32'h0, 32'h1234_5678, 1'b0};
    rows[16] = '{32'h1f0, 1'b0, 3'd4, 32'h1111_1111, 32'h1234_5678, 1'b1};
    rows[17] = '{32'h200, 1'b1, 3'd4, 32'h0, 32'h1234_5678, 1'b1};
    rows[18] = '{32'h00c, 1'b0, 3'd1, 32'h7700_0000, 32'h1234_5678, 1'b0};
    rows[19] = '{32'h00c, 1'b1, 3'd1, 32'h0, 32'h0000_0077, 1'b0};
    // Lower halfword and third byte lane
    rows[20] = '{32'h00c, 1'b0, 3'd2, 32'ha1b2_0000, 32'h0000_0077, 1'b0};
    rows[21] = '{32'h00e, 1'b0, 3'd1, 32'hc300_0000, 32'h0000_0077, 1'b0};
    rows[22] = '{32'h00e, 1'b1, 3'd1, 32'h0, 32'h0000_00c3, 1'b0};
    rows[23] = '{32'h00c, 1'b1, 3'd2, 32'h0, 32'h0000_a1b2, 1'b0};

    repeat (3) @(posedge wb_clk_i);
    rst_i <= 1'b0;
    repeat (2) @(posedge tck_i);

    for (int r = 0; r < NumRows && timeouts == 0; r++) begin
      run_row(rows[r]);
    end
    repeat (4) @(posedge tck_i);

    $display("checker errors: %0d, timeouts: %0d", chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
